/* rtl/ps2Pkg.sv */
//======================================
// PS/2 protocol constants
// Frame layout, prefix bytes and receiver stall limit
//======================================
package ps2Pkg;

    //======================================
    // Frame layout
    //======================================
    // Start, 8 data, odd parity, stop
    localparam int Ps2FrameBits = 11;
    // Wide enough to count one frame
    localparam int Ps2CountBits = 4;

    //======================================
    // Prefix bytes
    //======================================
    // Extended key follows
    localparam logic [7:0] ScanExtended = 8'hE0;
    // Key release follows
    localparam logic [7:0] ScanBreak = 8'hF0;

    //======================================
    // Stall recovery
    //======================================
    localparam int Ps2StallBits = 20;
    // About 2 ms at 50 MHz, far above one PS/2 bit time
    localparam logic [Ps2StallBits-1:0] Ps2StallCycles = 20'd100000;

endpackage

/* rtl/zxKeyPkg.sv */
//======================================
// Spectrum key matrix geometry
// Set 2 scan codes of every mapped key
//======================================
package zxKeyPkg;

    localparam int KeyRows = 8;                   // Half rows on A8..A15
    localparam int KeyCols = 5;                   // Bits D0..D4
    localparam int KeyRowBits = 3;                // Row index width
    localparam int KeyColBits = 3;                // Column index width

    typedef logic [KeyCols-1:0] keyRowT;          // Active low, 0 = pressed

    //======================================
    // Scan codes, grouped by Spectrum row
    //======================================
    localparam logic [7:0] ScanLeftShift = 8'h12;  // Row 0, caps shift
    localparam logic [7:0] ScanRightShift = 8'h59; // Row 0, caps shift
    localparam logic [7:0] ScanCtrl = 8'h14;       // Row 0, caps shift
    localparam logic [7:0] ScanZ = 8'h1A;
    localparam logic [7:0] ScanX = 8'h22;
    localparam logic [7:0] ScanC = 8'h21;
    localparam logic [7:0] ScanV = 8'h2A;
    localparam logic [7:0] ScanA = 8'h1C;          // Row 1
    localparam logic [7:0] ScanS = 8'h1B;
    localparam logic [7:0] ScanD = 8'h23;
    localparam logic [7:0] ScanF = 8'h2B;
    localparam logic [7:0] ScanG = 8'h34;
    localparam logic [7:0] ScanQ = 8'h15;          // Row 2
    localparam logic [7:0] ScanW = 8'h1D;
    localparam logic [7:0] ScanE = 8'h24;
    localparam logic [7:0] ScanR = 8'h2D;
    localparam logic [7:0] ScanT = 8'h2C;
    localparam logic [7:0] Scan1 = 8'h16;          // Row 3
    localparam logic [7:0] Scan2 = 8'h1E;
    localparam logic [7:0] Scan3 = 8'h26;
    localparam logic [7:0] Scan4 = 8'h25;
    localparam logic [7:0] Scan5 = 8'h2E;
    localparam logic [7:0] Scan0 = 8'h45;          // Row 4, right to left
    localparam logic [7:0] Scan9 = 8'h46;
    localparam logic [7:0] Scan8 = 8'h3E;
    localparam logic [7:0] Scan7 = 8'h3D;
    localparam logic [7:0] Scan6 = 8'h36;
    localparam logic [7:0] ScanP = 8'h4D;          // Row 5, right to left
    localparam logic [7:0] ScanO = 8'h44;
    localparam logic [7:0] ScanI = 8'h43;
    localparam logic [7:0] ScanU = 8'h3C;
    localparam logic [7:0] ScanY = 8'h35;
    localparam logic [7:0] ScanEnter = 8'h5A;      // Row 6, right to left
    localparam logic [7:0] ScanL = 8'h4B;
    localparam logic [7:0] ScanK = 8'h42;
    localparam logic [7:0] ScanJ = 8'h3B;
    localparam logic [7:0] ScanH = 8'h33;
    localparam logic [7:0] ScanSpace = 8'h29;      // Row 7, right to left
    localparam logic [7:0] ScanAlt = 8'h11;        // Symbol shift
    localparam logic [7:0] ScanM = 8'h3A;
    localparam logic [7:0] ScanN = 8'h31;
    localparam logic [7:0] ScanB = 8'h32;

endpackage

/* rtl/ps2Receiver.sv */
//======================================
// PS/2 receiver
// Deserializes keyboard frames into scan codes, flags bad frames
//======================================
`timescale 1ns/1ps

module ps2Receiver import ps2Pkg::*; (
    input  logic       clk,
    input  logic       reset,          // Active low, async
    input  logic       ps2Clk,         // Keyboard clock, async to clk
    input  logic       ps2Data,        // Keyboard data, async to clk
    output logic [7:0] scanCode,       // Valid while scanCodeReady
    output logic       scanCodeReady,  // One clock per good frame
    output logic       scanCodeError   // One clock per bad frame
);

    //======================================
    // Line synchronizers
    //======================================
    logic ps2ClkMeta;
    logic ps2ClkSync;
    logic ps2ClkPrev;                  // For edge detect
    logic ps2DataMeta;
    logic ps2DataSync;
    logic fallEdge;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ps2ClkMeta  <= 1'b1;       // Bus idles high
            ps2ClkSync  <= 1'b1;
            ps2ClkPrev  <= 1'b1;
            ps2DataMeta <= 1'b1;
            ps2DataSync <= 1'b1;
        end else begin
            ps2ClkMeta  <= ps2Clk;
            ps2ClkSync  <= ps2ClkMeta;
            ps2ClkPrev  <= ps2ClkSync;
            ps2DataMeta <= ps2Data;
            ps2DataSync <= ps2DataMeta;
        end
    end

    // Keyboard drives data on its falling clock edge
    assign fallEdge = ps2ClkPrev & ~ps2ClkSync;

    //======================================
    // Frame assembly
    //======================================
    logic [Ps2FrameBits-1:0] shiftReg;    // LSB first, start bit ends in bit 0
    logic [Ps2FrameBits-1:0] frameNext;   // Frame including the bit now sampled
    logic [Ps2CountBits-1:0] bitCount;
    logic                    lastBit;     // Stop bit arriving now
    logic                    frameGood;
    logic [Ps2StallBits-1:0] stallCount;
    logic                    stallTimeout;

    assign frameNext = {ps2DataSync, shiftReg[Ps2FrameBits-1:1]};
    assign lastBit   = fallEdge && (bitCount == Ps2CountBits'(Ps2FrameBits - 1));

    // Start low, stop high, odd parity over data plus parity
    assign frameGood = !frameNext[0]
                     && frameNext[Ps2FrameBits-1]
                     && (^frameNext[Ps2FrameBits-2:1]);

    always_ff @(posedge clk) begin
        if (fallEdge) begin
            shiftReg <= frameNext;                    // Payload, no reset
        end
        if (lastBit) begin
            scanCode <= frameNext[8:1];               // Data byte
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bitCount <= '0;
        end else if (lastBit) begin
            bitCount <= '0;                           // Frame done
        end else if (fallEdge) begin
            bitCount <= bitCount + 1'b1;
        end else if (stallTimeout) begin
            bitCount <= '0;                           // Drop partial frame
        end
    end

    //======================================
    // Result strobes
    //======================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scanCodeReady <= 1'b0;
            scanCodeError <= 1'b0;
        end else begin
            scanCodeReady <= lastBit && frameGood;    // Single cycle pulses
            scanCodeError <= lastBit && !frameGood;
        end
    end

    //======================================
    // Stall watchdog
    //======================================
    // Only runs while a frame is partly received
    assign stallTimeout = (stallCount == Ps2StallCycles);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            stallCount <= '0;
        end else if (fallEdge || (bitCount == '0)) begin
            stallCount <= '0;                         // Activity or idle
        end else if (!stallTimeout) begin
            stallCount <= stallCount + 1'b1;
        end else begin
            stallCount <= '0;                         // Counter cleared with frame
        end
    end

endmodule

/* rtl/zxKeyMatrix.sv */
//======================================
// Spectrum key matrix
// Applies PS/2 make/break codes to the 8x5 matrix, answers IN (FE)
//======================================
`timescale 1ns/1ps

module zxKeyMatrix import ps2Pkg::*, zxKeyPkg::*; (
    input  logic        clk,
    input  logic        reset,          // Active low, async
    input  logic [15:0] addr,           // CPU address bus, A8..A15 select rows
    input  logic [7:0]  scanCode,
    input  logic        scanCodeReady,
    input  logic        scanCodeError,
    output keyRowT      keyRow          // Active low key bits
);

    keyRowT keys [KeyRows];             // Matrix state, 1 = up
    logic   released;                   // F0 seen
    logic   extended;                   // E0 seen

    //======================================
    // Scan code to matrix position
    //======================================
    logic                  keyHit;
    logic [KeyRowBits-1:0] keyRowSel;
    logic [KeyColBits-1:0] keyColSel;

    always_comb begin
        {keyHit, keyRowSel, keyColSel} = '0;
        if (extended) begin
            case (scanCode)
                ScanCtrl: {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd0};  // Right Ctrl
                ScanAlt:  {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd1};  // AltGr
                default:  ;                                        // Other E0 keys ignored
            endcase
        end else begin
            case (scanCode)
                ScanLeftShift:  {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd0};
                ScanRightShift: {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd0};
                ScanCtrl:       {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd0};
                ScanZ:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd1};
                ScanX:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd2};
                ScanC:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd3};
                ScanV:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd0, 3'd4};
                ScanA:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd1, 3'd0};
                ScanS:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd1, 3'd1};
                ScanD:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd1, 3'd2};
                ScanF:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd1, 3'd3};
                ScanG:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd1, 3'd4};
                ScanQ:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd2, 3'd0};
                ScanW:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd2, 3'd1};
                ScanE:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd2, 3'd2};
                ScanR:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd2, 3'd3};
                ScanT:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd2, 3'd4};
                Scan1:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd3, 3'd0};
                Scan2:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd3, 3'd1};
                Scan3:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd3, 3'd2};
                Scan4:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd3, 3'd3};
                Scan5:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd3, 3'd4};
                Scan0:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd4, 3'd0};
                Scan9:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd4, 3'd1};
                Scan8:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd4, 3'd2};
                Scan7:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd4, 3'd3};
                Scan6:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd4, 3'd4};
                ScanP:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd5, 3'd0};
                ScanO:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd5, 3'd1};
                ScanI:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd5, 3'd2};
                ScanU:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd5, 3'd3};
                ScanY:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd5, 3'd4};
                ScanEnter:      {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd6, 3'd0};
                ScanL:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd6, 3'd1};
                ScanK:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd6, 3'd2};
                ScanJ:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd6, 3'd3};
                ScanH:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd6, 3'd4};
                ScanSpace:      {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd0};
                ScanAlt:        {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd1};
                ScanM:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd2};
                ScanN:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd3};
                ScanB:          {keyHit, keyRowSel, keyColSel} = {1'b1, 3'd7, 3'd4};
                default:        ;                                  // Unmapped, no change
            endcase
        end
    end

    //======================================
    // Prefix tracking and key state
    //======================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            released <= 1'b0;
            extended <= 1'b0;
            for (int r = 0; r < KeyRows; r++) begin
                keys[r] <= '1;                     // All keys up
            end
        end else if (scanCodeError) begin
            released <= 1'b0;                      // Bad frame breaks the sequence
            extended <= 1'b0;
        end else if (scanCodeReady) begin
            if (scanCode == ScanExtended) begin
                extended <= 1'b1;
            end else if (scanCode == ScanBreak) begin
                released <= 1'b1;
            end else begin
                released <= 1'b0;                  // Sequence complete
                extended <= 1'b0;
                if (keyHit) begin
                    // Last event wins for aliased keys
                    keys[keyRowSel][keyColSel] <= released;
                end
            end
        end
    end

    //======================================
    // Row read for IN (FE)
    //======================================
    always_comb begin
        keyRow = '1;                               // Nothing selected
        for (int r = 0; r < KeyRows; r++) begin
            if (!addr[8 + r]) begin
                keyRow &= keys[r];                 // Selected rows wire-AND
            end
        end
    end

endmodule

/* rtl/zxKeyboard.sv */
//======================================
// Spectrum keyboard subsystem
// PS/2 receiver feeding the key matrix
//======================================
`timescale 1ns/1ps

module zxKeyboard import zxKeyPkg::*; (
    input  logic        clk,
    input  logic        reset,          // Active low, async
    input  logic        ps2Clk,         // From keyboard connector
    input  logic        ps2Data,
    input  logic [15:0] addr,           // CPU address during IN (FE)
    output keyRowT      keyRow          // Key bits D0..D4
);

    logic [7:0] scanCode;
    logic       scanCodeReady;
    logic       scanCodeError;

    // Serial frames to scan code strobes
    ps2Receiver u_rx (
        .clk           (clk),
        .reset         (reset),
        .ps2Clk        (ps2Clk),
        .ps2Data       (ps2Data),
        .scanCode      (scanCode),
        .scanCodeReady (scanCodeReady),
        .scanCodeError (scanCodeError)
    );

    // Scan codes to matrix, matrix to data bus
    zxKeyMatrix u_matrix (
        .clk           (clk),
        .reset         (reset),
        .addr          (addr),
        .scanCode      (scanCode),
        .scanCodeReady (scanCodeReady),
        .scanCodeError (scanCodeError),
        .keyRow        (keyRow)
    );

endmodule

/* dv/zxKeyboardTb.sv */
//======================================
// Keyboard subsystem testbench
// PS/2 keyboard model, reference key matrix, row checks
//======================================
`timescale 1ns/1ps

module zxKeyboardTb import ps2Pkg::*, zxKeyPkg::*; ();

    localparam int FramesSent = 56;                   // Sum over all tests below
    localparam int TimeoutCycles = FramesSent * 100 * 2;

    logic        clk;
    logic        reset;
    logic        ps2Clk;
    logic        ps2Data;
    logic [15:0] addr;
    keyRowT      keyRow;

    keyRowT refKeys [KeyRows];                        // Expected matrix, 1 = up
    bit     refRel;                                   // F0 pending
    bit     refExt;                                   // E0 pending
    int     seed = 32'h3f5b04a3;
    int     checkCount = 0;
    int     errorCount = 0;
    int     testErrors;
    int     cycleCount;
    string  testName;
    event   checkReq;
    event   checkDone;

    // Spectrum layout, row r column c
    logic [7:0] keyCodes [KeyRows][KeyCols] = '{
        '{ScanLeftShift, ScanZ, ScanX, ScanC, ScanV},
        '{ScanA, ScanS, ScanD, ScanF, ScanG},
        '{ScanQ, ScanW, ScanE, ScanR, ScanT},
        '{Scan1, Scan2, Scan3, Scan4, Scan5},
        '{Scan0, Scan9, Scan8, Scan7, Scan6},
        '{ScanP, ScanO, ScanI, ScanU, ScanY},
        '{ScanEnter, ScanL, ScanK, ScanJ, ScanH},
        '{ScanSpace, ScanAlt, ScanM, ScanN, ScanB}
    };

    zxKeyboard dut (
        .clk     (clk),
        .reset   (reset),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .addr    (addr),
        .keyRow  (keyRow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                       // 100 ns period
    end

    //======================================
    // Reference model
    //======================================
    function automatic bit findKey(input logic [7:0] code, input bit ext,
                                   output int row, output int col);
        int r;
        int c;
        row = 0;
        col = 0;
        if (ext) begin
            if (code == ScanAlt) begin
                row = 7;                              // AltGr, symbol shift
                col = 1;
            end
            return (code == ScanCtrl) || (code == ScanAlt);
        end
        if ((code == ScanRightShift) || (code == ScanCtrl)) begin
            return 1'b1;                              // Caps shift aliases
        end
        for (r = 0; r < KeyRows; r++) begin
            for (c = 0; c < KeyCols; c++) begin
                if (keyCodes[r][c] == code) begin
                    row = r;
                    col = c;
                    return 1'b1;
                end
            end
        end
        return 1'b0;                                  // Unmapped
    endfunction

    function automatic void applyRef(input logic [7:0] code, input bit bad);
        int row;
        int col;
        if (bad) begin
            refRel = 1'b0;                            // Sequence lost, keys kept
            refExt = 1'b0;
        end else if (code == ScanExtended) begin
            refExt = 1'b1;
        end else if (code == ScanBreak) begin
            refRel = 1'b1;
        end else begin
            if (findKey(code, refExt, row, col)) begin
                refKeys[row][col] = refRel;
            end
            refRel = 1'b0;
            refExt = 1'b0;
        end
    endfunction

    function automatic keyRowT expectedRow(input logic [15:0] a);
        keyRowT row;
        int r;
        row = '1;                                     // No row selected
        for (r = 0; r < KeyRows; r++) begin
            if (!a[8 + r]) begin
                row = row & refKeys[r];
            end
        end
        return row;
    endfunction

    //======================================
    // Checking
    //======================================
    task automatic checkRow(input string name, input keyRowT expected, input keyRowT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s: addr %h, expected %b, actual %b",
                     name, addr, expected, actual);
        end
    endtask

    // Compare process, samples away from the clock edge
    initial begin
        forever begin
            @(checkReq);
            repeat (8) @(posedge clk);
            @(negedge clk);
            checkRow(testName, expectedRow(addr), keyRow);
            -> checkDone;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run did not finish within %0d clock cycles", TimeoutCycles);
        $display("Checks failed");
        $finish;
    end

    task automatic requestCheck();
        @(posedge clk);
        -> checkReq;
        @(checkDone);
    endtask

    task automatic checkAddr(input logic [15:0] a);
        @(posedge clk);
        addr <= a;
        requestCheck();
    endtask

    //======================================
    // PS/2 keyboard model
    //======================================
    task automatic sendFrame(input logic [7:0] code, input bit badParity);
        logic [Ps2FrameBits-1:0] frame;
        int i;
        frame = {1'b1, (~^code) ^ badParity, code, 1'b0};  // Stop, parity, data, start
        for (i = 0; i < Ps2FrameBits; i++) begin
            repeat (2) @(posedge clk);
            ps2Data <= frame[i];                      // Change while clock high
            repeat (2) @(posedge clk);
            ps2Clk <= 1'b0;
            repeat (4) @(posedge clk);
            ps2Clk <= 1'b1;
        end
        repeat (4) @(posedge clk);
        applyRef(code, badParity);
        requestCheck();
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == testErrors) begin
            $display("test %s: ok", testName);
        end else begin
            $display("test %s: %0d errors", testName, errorCount - testErrors);
        end
    endtask

    //======================================
    // Tests
    //======================================
    initial begin
        int n;
        int row;
        int col;
        int heldRow [5];
        int heldCol [5];
        logic [15:0] a;
        reset = 1'b0;
        ps2Clk = 1'b1;                                // Bus idle
        ps2Data = 1'b1;
        addr = 16'hFFFF;
        refRel = 1'b0;
        refExt = 1'b0;
        for (n = 0; n < KeyRows; n++) begin
            refKeys[n] = '1;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b1;

        startTest("reset and unmapped");
        checkAddr(16'hFEFE);
        checkAddr(16'hFFFE);                          // No row, all ones
        checkAddr(16'h00FE);                          // Every row
        sendFrame(8'h76, 1'b0);                       // Esc
        sendFrame(8'h05, 1'b0);                       // F1
        endTest();

        startTest("press and release");
        for (n = 0; n < 4; n++) begin
            row = {$random(seed)} % KeyRows;
            col = {$random(seed)} % KeyCols;
            @(posedge clk);
            addr <= {~(8'd1 << row), 8'hFE};
            sendFrame(keyCodes[row][col], 1'b0);
            sendFrame(ScanBreak, 1'b0);
            sendFrame(keyCodes[row][col], 1'b0);
        end
        endTest();

        startTest("row selection");
        for (n = 0; n < 5; n++) begin
            heldRow[n] = {$random(seed)} % KeyRows;
            heldCol[n] = {$random(seed)} % KeyCols;
            sendFrame(keyCodes[heldRow[n]][heldCol[n]], 1'b0);  // Leave keys held
        end
        for (n = 0; n < KeyRows; n++) begin
            checkAddr({~(8'd1 << n), 8'hFE});
        end
        for (n = 0; n < 8; n++) begin
            a = 16'($random(seed));
            if (a[15:8] == 8'hFF) begin
                a[15:8] = a[15:8] & ~(8'd1 << ({$random(seed)} % 8));
            end
            checkAddr(a);
        end
        checkAddr(16'hFF00);
        @(posedge clk);
        addr <= 16'h00FE;                             // Every row
        for (n = 0; n < 5; n++) begin
            sendFrame(ScanBreak, 1'b0);               // Let go of held keys
            sendFrame(keyCodes[heldRow[n]][heldCol[n]], 1'b0);
        end
        endTest();

        startTest("aliases");
        checkAddr(16'hFEFE);                          // Caps shift row
        sendFrame(ScanLeftShift, 1'b0);
        sendFrame(ScanRightShift, 1'b0);
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanLeftShift, 1'b0);               // Last event releases
        sendFrame(ScanCtrl, 1'b0);
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanRightShift, 1'b0);
        endTest();

        startTest("extended codes");
        checkAddr(16'h7EFE);                          // Rows 0 and 7
        sendFrame(ScanExtended, 1'b0);
        sendFrame(ScanCtrl, 1'b0);
        sendFrame(ScanExtended, 1'b0);
        sendFrame(ScanAlt, 1'b0);
        sendFrame(ScanExtended, 1'b0);
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanCtrl, 1'b0);
        sendFrame(ScanExtended, 1'b0);
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanAlt, 1'b0);
        sendFrame(ScanExtended, 1'b0);
        sendFrame(ScanZ, 1'b0);                       // Ignored when extended
        sendFrame(ScanZ, 1'b0);
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanZ, 1'b0);
        endTest();

        startTest("frame errors");
        checkAddr(16'hFBFE);                          // Row 2
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanQ, 1'b1);                       // Bad parity
        sendFrame(ScanQ, 1'b0);                       // Now a press
        sendFrame(ScanBreak, 1'b0);
        sendFrame(ScanQ, 1'b0);
        endTest();

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* zxKeyboard.f */
rtl/ps2Pkg.sv
rtl/zxKeyPkg.sv
rtl/ps2Receiver.sv
rtl/zxKeyMatrix.sv
rtl/zxKeyboard.sv
dv/zxKeyboardTb.sv

/* Makefile */
# Verilator simulation of the keyboard subsystem

TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := zxKeyboardTb
FILELIST := zxKeyboard.f
OBJDIR   := obj_dir
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)
